// ==== immu_pkg.sv ====
/*
 Shared ITLB entry layouts, SPR address map and page geometry
 Fixed 8 KB pages and 32-bit operands, only way 0 of the ITLB exists
*/
package immu_pkg;

   localparam int unsigned OPERAND_WIDTH = 32;
   localparam int unsigned PAGE_BITS = 13;                       // 8 KB pages
   localparam int unsigned VPN_WIDTH = OPERAND_WIDTH - PAGE_BITS; // 19 bits

   // Match register layout
   typedef struct packed {
      logic [VPN_WIDTH-1:0] vpn;     // Virtual page number
      logic [11:0]          rsvd;    // Ignored by the compare
      logic                 valid;   // Entry in use
   } itlb_match_t;

   // Translate register layout
   typedef struct packed {
      logic [VPN_WIDTH-1:0] ppn;     // Physical page number
      logic [4:0]           rsvd_hi;
      logic                 uxe;     // User execute enable
      logic                 sxe;     // Supervisor execute enable
      logic [3:0]           rsvd_mid;
      logic                 ci;      // Cache inhibit
      logic                 rsvd_lo;
   } itlb_trans_t;

   // SPR group of the instruction MMU, found in address bits 15..11
   localparam logic [4:0] SPR_GROUP_IMMU = 5'd2;

   // Way 0 windows, 128 registers each
   localparam logic [15:0] SPR_ITLBW0MR0 = 16'h1200;   // First match register
   localparam logic [15:0] SPR_ITLBW0TR0 = 16'h1280;   // First translate register
   localparam logic [15:0] SPR_ITLBW1MR0 = 16'h1300;   // Way 1 and up not built

endpackage

// ==== tlb_dpram.sv ====
/*
 Single clock true dual port RAM holding one entry type per word
 Reads return old data on a write to the same address
 Contents are not cleared by reset, never write one address from both ports
*/
module tlb_dpram #(
   parameter int  ADDR_WIDTH = 6,
   parameter type entry_t    = logic [31:0]
) (
   input  logic                  clk,
   // Lookup port
   input  logic [ADDR_WIDTH-1:0] addr_a_i,
   input  logic                  we_a_i,
   input  entry_t                din_a_i,
   output entry_t                dout_a_o,
   // SPR port
   input  logic [ADDR_WIDTH-1:0] addr_b_i,
   input  logic                  we_b_i,
   input  entry_t                din_b_i,
   output entry_t                dout_b_o
);

   localparam int DEPTH = 2 ** ADDR_WIDTH;

   entry_t mem [DEPTH];   // One entry per set

   always_ff @(posedge clk) begin
      dout_a_o <= mem[addr_a_i];     // Registered read, sees old contents
      dout_b_o <= mem[addr_b_i];
      if (we_a_i) begin
         mem[addr_a_i] <= din_a_i;
      end
      if (we_b_i) begin
         mem[addr_b_i] <= din_b_i;   // Port B wins, though callers never collide
      end
   end

   // Port collision on one word would leave its contents ill defined
   a_no_dual_write: assert property (
      @(posedge clk) !(we_a_i && we_b_i && (addr_a_i == addr_b_i))
   ) else $error("tlb_dpram: both ports write address %0d", addr_a_i);

endmodule

// ==== immu_spr_port.sv ====
/*
 SPR group 2 slave for the way 0 ITLB arrays
 Master must hold strobe, address and data until the ack, then drop strobe
 Group 2 addresses outside the populated sets ack, read zero, ignore writes
*/
module immu_spr_port #(
   parameter int SET_WIDTH = 6
) (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               spr_stb_i,
   input  logic                               spr_we_i,
   input  logic [15:0]                        spr_addr_i,
   output logic [immu_pkg::OPERAND_WIDTH-1:0] spr_dat_o,
   output logic                               spr_ack_o,
   output logic                               match_we_o,
   output logic                               trans_we_o,
   output logic [SET_WIDTH-1:0]               set_addr_o,
   input  logic [immu_pkg::OPERAND_WIDTH-1:0] match_rd_i,
   input  logic [immu_pkg::OPERAND_WIDTH-1:0] trans_rd_i
);

   // Populated sets inside a 128 register window, 128 fits in 8 bits
   localparam logic [7:0] NUM_SETS = 8'(1 << SET_WIDTH);

   logic grp_hit;      // Address in the IMMU group
   logic first_stb;    // First sampled edge of this access
   logic set_ok;       // Offset within populated sets
   logic match_cs;
   logic trans_cs;
   logic ack_q;
   logic match_cs_q;   // Steers read data in the ack cycle
   logic trans_cs_q;

   assign grp_hit = spr_addr_i[15:11] == immu_pkg::SPR_GROUP_IMMU;
   assign first_stb = spr_stb_i & grp_hit & ~ack_q;   // Held strobe not taken twice

   // Upper window offsets would alias onto low sets
   assign set_ok = {1'b0, spr_addr_i[6:0]} < NUM_SETS;

   assign match_cs = first_stb & set_ok &
                     (spr_addr_i >= immu_pkg::SPR_ITLBW0MR0) &
                     (spr_addr_i < immu_pkg::SPR_ITLBW0TR0);
   assign trans_cs = first_stb & set_ok &
                     (spr_addr_i >= immu_pkg::SPR_ITLBW0TR0) &
                     (spr_addr_i < immu_pkg::SPR_ITLBW1MR0);

   assign match_we_o = match_cs & spr_we_i;   // Write lands on the sample edge
   assign trans_we_o = trans_cs & spr_we_i;
   assign set_addr_o = spr_addr_i[SET_WIDTH-1:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q      <= 1'b0;
         match_cs_q <= 1'b0;
         trans_cs_q <= 1'b0;
      end else begin
         ack_q      <= first_stb;   // One cycle pulse
         match_cs_q <= match_cs;
         trans_cs_q <= trans_cs;
      end
   end

   assign spr_ack_o = ack_q & spr_stb_i;   // Dropped strobe kills a stale ack

   // RAM port B output is valid in the ack cycle
   always_comb begin
      if (match_cs_q) begin
         spr_dat_o = match_rd_i;
      end else if (trans_cs_q) begin
         spr_dat_o = trans_rd_i;
      end else begin
         spr_dat_o = '0;   // Unpopulated or idle
      end
   end

   // Ack only answers a strobe and address held across the sample edge
   a_ack_held_req: assert property (
      @(posedge clk) disable iff (rst)
      spr_ack_o |-> (spr_stb_i && $past(spr_stb_i) && $stable(spr_addr_i))
   ) else $error("immu_spr_port: ack without a held request");

endmodule

// ==== immu.sv ====
/*
 Direct mapped single way instruction MMU
 Lookup index is registered in the RAMs, compare uses the match cycle address
 TLB contents are unknown until software fills them over the SPR bus
*/
module immu #(
   parameter int SET_WIDTH = 6   // Legal from 1 to 7
) (
   input  logic                               clk,
   input  logic                               rst,
   // Translation
   input  logic [immu_pkg::OPERAND_WIDTH-1:0] virt_addr_i,        // Lookup cycle
   input  logic [immu_pkg::OPERAND_WIDTH-1:0] virt_addr_match_i,  // Match cycle
   input  logic                               supervisor_mode_i,  // Match cycle
   output logic [immu_pkg::OPERAND_WIDTH-1:0] phys_addr_o,
   output logic                               cache_inhibit_o,
   output logic                               tlb_miss_o,
   output logic                               pagefault_o,
   // SPR bus
   input  logic                               spr_stb_i,
   input  logic                               spr_we_i,
   input  logic [15:0]                        spr_addr_i,
   input  logic [immu_pkg::OPERAND_WIDTH-1:0] spr_dat_i,
   output logic [immu_pkg::OPERAND_WIDTH-1:0] spr_dat_o,
   output logic                               spr_ack_o
);

   logic [SET_WIDTH-1:0]  lookup_idx;
   logic [SET_WIDTH-1:0]  spr_idx;
   logic                  match_we;
   logic                  trans_we;
   immu_pkg::itlb_match_t match_ent;    // Lookup side read
   immu_pkg::itlb_trans_t trans_ent;
   immu_pkg::itlb_match_t match_spr;    // SPR side read
   immu_pkg::itlb_trans_t trans_spr;
   logic                  hit;
   logic                  exec_ok;

   // Set index sits just above the page offset
   assign lookup_idx = virt_addr_i[immu_pkg::PAGE_BITS +: SET_WIDTH];

   tlb_dpram #(
      .ADDR_WIDTH (SET_WIDTH),
      .entry_t    (immu_pkg::itlb_match_t)
   ) u_itlb_match (
      .clk      (clk),
      .addr_a_i (lookup_idx),
      .we_a_i   (1'b0),         // Lookup port only reads
      .din_a_i  ('0),
      .dout_a_o (match_ent),
      .addr_b_i (spr_idx),
      .we_b_i   (match_we),
      .din_b_i  (immu_pkg::itlb_match_t'(spr_dat_i)),
      .dout_b_o (match_spr)
   );

   tlb_dpram #(
      .ADDR_WIDTH (SET_WIDTH),
      .entry_t    (immu_pkg::itlb_trans_t)
   ) u_itlb_trans (
      .clk      (clk),
      .addr_a_i (lookup_idx),
      .we_a_i   (1'b0),
      .din_a_i  ('0),
      .dout_a_o (trans_ent),
      .addr_b_i (spr_idx),
      .we_b_i   (trans_we),
      .din_b_i  (immu_pkg::itlb_trans_t'(spr_dat_i)),
      .dout_b_o (trans_spr)
   );

   immu_spr_port #(
      .SET_WIDTH (SET_WIDTH)
   ) u_spr_port (
      .clk        (clk),
      .rst        (rst),
      .spr_stb_i  (spr_stb_i),
      .spr_we_i   (spr_we_i),
      .spr_addr_i (spr_addr_i),
      .spr_dat_o  (spr_dat_o),
      .spr_ack_o  (spr_ack_o),
      .match_we_o (match_we),
      .trans_we_o (trans_we),
      .set_addr_o (spr_idx),
      .match_rd_i (match_spr),
      .trans_rd_i (trans_spr)
   );

   // Full vpn compare, index bits included since the RAM read was by index
   assign hit = match_ent.valid &&
                (match_ent.vpn == virt_addr_match_i[immu_pkg::OPERAND_WIDTH-1:
                                                    immu_pkg::PAGE_BITS]);
   assign tlb_miss_o = ~hit;

   // Execute permission of the requesting mode
   assign exec_ok = supervisor_mode_i ? trans_ent.sxe : trans_ent.uxe;
   assign pagefault_o = hit & ~exec_ok;   // No fault reported on a miss

   assign phys_addr_o = {trans_ent.ppn, virt_addr_match_i[immu_pkg::PAGE_BITS-1:0]};
   assign cache_inhibit_o = trans_ent.ci;

endmodule

// ==== fetch_xlate_stage.sv ====
/*
 Fetch request register around the ITLB lookup
 No back pressure, one request per cycle, response exactly one cycle later
 Response data are meaningless while rsp_valid_o is low
*/
module fetch_xlate_stage (
   input  logic                               clk,
   input  logic                               rst,
   // Fetch request
   input  logic                               fetch_req_i,
   input  logic [immu_pkg::OPERAND_WIDTH-1:0] fetch_addr_i,
   input  logic                               fetch_super_i,
   // MMU side
   output logic [immu_pkg::OPERAND_WIDTH-1:0] lookup_addr_o,
   output logic [immu_pkg::OPERAND_WIDTH-1:0] match_addr_o,
   output logic                               match_super_o,
   input  logic                               miss_i,
   input  logic                               pagefault_i,
   input  logic [immu_pkg::OPERAND_WIDTH-1:0] phys_addr_i,
   input  logic                               ci_i,
   // Response
   output logic                               rsp_valid_o,
   output logic [immu_pkg::OPERAND_WIDTH-1:0] rsp_phys_addr_o,
   output logic                               rsp_ci_o,
   output logic                               rsp_miss_o,
   output logic                               rsp_pagefault_o
);

   logic                               req_q;     // Lookup in its match cycle
   logic [immu_pkg::OPERAND_WIDTH-1:0] addr_q;
   logic                               super_q;

   // RAMs sample the index on the request edge
   assign lookup_addr_o = fetch_addr_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         req_q <= 1'b0;
      end else begin
         req_q <= fetch_req_i;
      end
   end

   // Payload held only for real requests
   always_ff @(posedge clk) begin
      if (fetch_req_i) begin
         addr_q  <= fetch_addr_i;
         super_q <= fetch_super_i;
      end
   end

   assign match_addr_o  = addr_q;
   assign match_super_o = super_q;

   // Flags forced low outside a valid response
   assign rsp_valid_o     = req_q;
   assign rsp_phys_addr_o = phys_addr_i;
   assign rsp_ci_o        = req_q & ci_i;
   assign rsp_miss_o      = req_q & miss_i;
   assign rsp_pagefault_o = req_q & pagefault_i;   // Already gated by hit in the MMU

   // Unfilled TLB sets show up here as unknown flags
   a_flags_known: assert property (
      @(posedge clk) disable iff (rst)
      rsp_valid_o |-> !$isunknown({rsp_miss_o, rsp_pagefault_o})
   ) else $error("fetch_xlate_stage: unknown miss or fault on a valid response");

endmodule

// ==== immu_top.sv ====
/*
 Instruction address translation path, fetch stage over the ITLB
 SET_WIDTH from 1 to 7, fill the TLB over the SPR bus before fetching
*/
module immu_top #(
   parameter int SET_WIDTH = 6
) (
   input  logic                               clk,
   input  logic                               rst,
   // Fetch request and response
   input  logic                               fetch_req_i,
   input  logic [immu_pkg::OPERAND_WIDTH-1:0] fetch_addr_i,
   input  logic                               fetch_super_i,
   output logic                               rsp_valid_o,
   output logic [immu_pkg::OPERAND_WIDTH-1:0] rsp_phys_addr_o,
   output logic                               rsp_ci_o,
   output logic                               rsp_miss_o,
   output logic                               rsp_pagefault_o,
   // SPR bus
   input  logic                               spr_stb_i,
   input  logic                               spr_we_i,
   input  logic [15:0]                        spr_addr_i,
   input  logic [immu_pkg::OPERAND_WIDTH-1:0] spr_dat_i,
   output logic [immu_pkg::OPERAND_WIDTH-1:0] spr_dat_o,
   output logic                               spr_ack_o
);

   logic [immu_pkg::OPERAND_WIDTH-1:0] lookup_addr;   // Request cycle
   logic [immu_pkg::OPERAND_WIDTH-1:0] match_addr;    // Match cycle
   logic                               match_super;
   logic [immu_pkg::OPERAND_WIDTH-1:0] phys_addr;
   logic                               ci;
   logic                               miss;
   logic                               pagefault;

   fetch_xlate_stage u_fetch (
      .clk             (clk),
      .rst             (rst),
      .fetch_req_i     (fetch_req_i),
      .fetch_addr_i    (fetch_addr_i),
      .fetch_super_i   (fetch_super_i),
      .lookup_addr_o   (lookup_addr),
      .match_addr_o    (match_addr),
      .match_super_o   (match_super),
      .miss_i          (miss),
      .pagefault_i     (pagefault),
      .phys_addr_i     (phys_addr),
      .ci_i            (ci),
      .rsp_valid_o     (rsp_valid_o),
      .rsp_phys_addr_o (rsp_phys_addr_o),
      .rsp_ci_o        (rsp_ci_o),
      .rsp_miss_o      (rsp_miss_o),
      .rsp_pagefault_o (rsp_pagefault_o)
   );

   immu #(
      .SET_WIDTH (SET_WIDTH)
   ) u_immu (
      .clk               (clk),
      .rst               (rst),
      .virt_addr_i       (lookup_addr),
      .virt_addr_match_i (match_addr),
      .supervisor_mode_i (match_super),
      .phys_addr_o       (phys_addr),
      .cache_inhibit_o   (ci),
      .tlb_miss_o        (miss),
      .pagefault_o       (pagefault),
      .spr_stb_i         (spr_stb_i),
      .spr_we_i          (spr_we_i),
      .spr_addr_i        (spr_addr_i),
      .spr_dat_i         (spr_dat_i),
      .spr_dat_o         (spr_dat_o),
      .spr_ack_o         (spr_ack_o)
   );

endmodule

// ==== tb_immu.sv ====
/*
 Directed testbench for immu_top with a reference model of both ITLB arrays
 SET_WIDTH below must equal the immu_top default
 All sets are filled over the SPR bus before the first lookup
*/
module tb_immu;

   localparam int SET_WIDTH = 6;              // Same as immu_top default
   localparam int NUM_SETS = 2 ** SET_WIDTH;
   localparam int TIMEOUT_CYCLES = 3000;      // Fill, readback and lookups, with margin
   localparam int AW = immu_pkg::OPERAND_WIDTH;
   localparam int PB = immu_pkg::PAGE_BITS;

   logic          clk;
   logic          rst;
   logic          fetch_req;
   logic [AW-1:0] fetch_addr;
   logic          fetch_super;
   logic          rsp_valid;
   logic [AW-1:0] rsp_phys_addr;
   logic          rsp_ci;
   logic          rsp_miss;
   logic          rsp_pagefault;
   logic          spr_stb;
   logic          spr_we;
   logic [15:0]   spr_addr;
   logic [AW-1:0] spr_wdata;
   logic [AW-1:0] spr_rdata;
   logic          spr_ack;

   immu_pkg::itlb_match_t ref_match [NUM_SETS];   // Model of the match array
   immu_pkg::itlb_trans_t ref_trans [NUM_SETS];   // Model of the translate array
   logic [AW-1:0] req_addr_q [$];                 // Lookups waiting to be issued
   logic          req_super_q [$];

   int cycle_count = 0;
   int err_count = 0;
   int check_count = 0;
   int test_count = 0;

   immu_top #(
      .SET_WIDTH (SET_WIDTH)
   ) i_immu_top (
      .clk             (clk),
      .rst             (rst),
      .fetch_req_i     (fetch_req),
      .fetch_addr_i    (fetch_addr),
      .fetch_super_i   (fetch_super),
      .rsp_valid_o     (rsp_valid),
      .rsp_phys_addr_o (rsp_phys_addr),
      .rsp_ci_o        (rsp_ci),
      .rsp_miss_o      (rsp_miss),
      .rsp_pagefault_o (rsp_pagefault),
      .spr_stb_i       (spr_stb),
      .spr_we_i        (spr_we),
      .spr_addr_i      (spr_addr),
      .spr_dat_i       (spr_wdata),
      .spr_dat_o       (spr_rdata),
      .spr_ack_o       (spr_ack)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;   // Period 100

   // Run limit
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: simulation ran past %0d cycles without finishing", TIMEOUT_CYCLES);
         $display("Regression failed");
         $finish;
      end
   end

   task automatic report_error(input string msg);
      err_count++;
      $display("[ERROR] %0t: %s", $time, msg);
   endtask

   task automatic note_failure(input string msg);
      err_count++;
      $display("%0t: %s", $time, msg);   // Protocol problems, not wrong values
   endtask

   task automatic check_word(input string what, input logic [AW-1:0] got,
                             input logic [AW-1:0] exp);
      check_count++;
      if (got !== exp) begin
         report_error($sformatf("%s: got %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_match(input string what, input immu_pkg::itlb_match_t got,
                              input immu_pkg::itlb_match_t exp);
      check_count++;
      if (got !== exp) begin
         report_error($sformatf("%s: got vpn %h valid %b, expected vpn %h valid %b (%h/%h)",
                                what, got.vpn, got.valid, exp.vpn, exp.valid, got, exp));
      end
   endtask

   task automatic check_trans(input string what, input immu_pkg::itlb_trans_t got,
                              input immu_pkg::itlb_trans_t exp);
      check_count++;
      if (got !== exp) begin
         report_error($sformatf("%s: got ppn %h uxe %b sxe %b ci %b, expected %h %b %b %b",
                                what, got.ppn, got.uxe, got.sxe, got.ci,
                                exp.ppn, exp.uxe, exp.sxe, exp.ci));
      end
   endtask

   task automatic check_flags(input string what, input logic got_miss, input logic got_fault,
                              input logic got_ci, input logic exp_miss,
                              input logic exp_fault, input logic exp_ci);
      check_count++;
      if ({got_miss, got_fault, got_ci} !== {exp_miss, exp_fault, exp_ci}) begin
         report_error($sformatf("%s: miss/fault/ci got %b%b%b, expected %b%b%b", what,
                                got_miss, got_fault, got_ci, exp_miss, exp_fault, exp_ci));
      end
   endtask

   // One SPR access, entered and left just after a falling edge
   task automatic spr_access(input logic we, input logic [15:0] addr,
                             input logic [AW-1:0] wdata, output logic [AW-1:0] rdata,
                             output logic acked);
      int waited;
      acked = 1'b0;
      rdata = '0;
      waited = 0;
      spr_stb = 1'b1;
      spr_we = we;
      spr_addr = addr;
      spr_wdata = wdata;
      while (!acked && waited < 10) begin   // 10 cycle ack limit
         @(negedge clk);
         waited++;
         if (spr_ack === 1'b1) begin
            acked = 1'b1;
            rdata = spr_rdata;             // Valid during the ack cycle
         end
      end
      if (acked && waited != 1) begin
         note_failure($sformatf("SPR ack at %h came %0d cycles after the strobe", addr, waited));
      end
      spr_stb = 1'b0;
      spr_we = 1'b0;
      @(negedge clk);                      // Strobe low for one cycle
   endtask

   task automatic spr_write(input logic [15:0] addr, input logic [AW-1:0] data);
      logic [AW-1:0] rd_unused;
      logic          acked;
      spr_access(1'b1, addr, data, rd_unused, acked);
      if (!acked) begin
         note_failure($sformatf("SPR write to %h was never acknowledged", addr));
      end
   endtask

   task automatic spr_read(input logic [15:0] addr, output logic [AW-1:0] data);
      logic acked;
      spr_access(1'b0, addr, '0, data, acked);
      if (!acked) begin
         note_failure($sformatf("SPR read from %h was never acknowledged", addr));
      end
   endtask

   task automatic write_match(input logic [SET_WIDTH-1:0] set, input immu_pkg::itlb_match_t e);
      spr_write(immu_pkg::SPR_ITLBW0MR0 | 16'(set), e);
      ref_match[set] = e;
   endtask

   task automatic write_trans(input logic [SET_WIDTH-1:0] set, input immu_pkg::itlb_trans_t e);
      spr_write(immu_pkg::SPR_ITLBW0TR0 | 16'(set), e);
      ref_trans[set] = e;
   endtask

   task automatic readback_set(input logic [SET_WIDTH-1:0] set);
      logic [AW-1:0] rd;
      spr_read(immu_pkg::SPR_ITLBW0MR0 | 16'(set), rd);
      check_match($sformatf("match readback set %0d", set), immu_pkg::itlb_match_t'(rd),
                  ref_match[set]);
      spr_read(immu_pkg::SPR_ITLBW0TR0 | 16'(set), rd);
      check_trans($sformatf("trans readback set %0d", set), immu_pkg::itlb_trans_t'(rd),
                  ref_trans[set]);
   endtask

   // Model prediction for one lookup, checked against the current response
   task automatic verify_response(input logic [AW-1:0] addr, input logic sup);
      logic [SET_WIDTH-1:0]  idx;
      immu_pkg::itlb_match_t m;
      immu_pkg::itlb_trans_t t;
      logic                  hit;
      logic                  exp_fault;
      idx = addr[PB +: SET_WIDTH];
      m = ref_match[idx];
      t = ref_trans[idx];
      hit = m.valid && (m.vpn == addr[AW-1:PB]);
      exp_fault = hit && !(sup ? t.sxe : t.uxe);   // Execute bit of the mode
      if (rsp_valid !== 1'b1) begin
         note_failure($sformatf("No response one cycle after lookup of %h", addr));
      end
      check_flags($sformatf("lookup %h super %b", addr, sup), rsp_miss, rsp_pagefault,
                  rsp_ci, !hit, exp_fault, t.ci);
      if (hit) begin
         check_word($sformatf("phys addr of %h", addr), rsp_phys_addr,
                    {t.ppn, addr[PB-1:0]});
      end
   endtask

   task automatic push_lookup(input logic [AW-1:0] addr, input logic sup);
      req_addr_q.push_back(addr);
      req_super_q.push_back(sup);
   endtask

   // Back to back requests, each response checked one cycle later
   task automatic issue_lookups();
      logic          pend;
      logic [AW-1:0] pend_addr;
      logic          pend_super;
      pend = 1'b0;
      pend_addr = '0;
      pend_super = 1'b0;
      while (req_addr_q.size() > 0 || pend) begin
         if (pend) verify_response(pend_addr, pend_super);
         if (req_addr_q.size() > 0) begin
            pend_addr = req_addr_q.pop_front();
            pend_super = req_super_q.pop_front();
            fetch_req = 1'b1;
            fetch_addr = pend_addr;
            fetch_super = pend_super;
            pend = 1'b1;
         end else begin
            fetch_req = 1'b0;
            pend = 1'b0;
         end
         @(negedge clk);
      end
      if (rsp_valid !== 1'b0) begin
         note_failure("Response valid stayed high with no request");
      end
   endtask

   task automatic end_test(input string name, input int errs_at_start);
      test_count++;
      $display("Test %s finished with %0d errors", name, err_count - errs_at_start);
   endtask

   task automatic fill_and_read_back();
      int e0;
      e0 = err_count;
      for (int s = 0; s < NUM_SETS; s++) begin
         write_match(SET_WIDTH'(s), immu_pkg::itlb_match_t'($urandom()));
         write_trans(SET_WIDTH'(s), immu_pkg::itlb_trans_t'($urandom()));
      end
      for (int s = 0; s < NUM_SETS; s++) readback_set(SET_WIDTH'(s));
      end_test("write_readback", e0);
   endtask

   task automatic translate_hits();
      int                    e0;
      immu_pkg::itlb_match_t m;
      e0 = err_count;
      for (int s = 0; s < NUM_SETS; s++) begin
         m = immu_pkg::itlb_match_t'($urandom());
         m.valid = 1'b1;
         m.vpn[SET_WIDTH-1:0] = SET_WIDTH'(s);   // Index bits pick this set
         write_match(SET_WIDTH'(s), m);
      end
      for (int s = 0; s < NUM_SETS; s++) begin
         push_lookup({ref_match[s].vpn, 13'($urandom())}, 1'($urandom()));
      end
      issue_lookups();
      end_test("hit_translation", e0);
   endtask

   task automatic detect_misses();
      int                    e0;
      immu_pkg::itlb_match_t m;
      logic [AW-1:0]         base;
      e0 = err_count;
      m = ref_match[5];
      base = {m.vpn, 13'h0a4};
      m.valid = 1'b0;
      write_match(SET_WIDTH'(5), m);
      push_lookup(base, 1'b0);
      push_lookup(base, 1'b1);
      issue_lookups();
      m.valid = 1'b1;
      write_match(SET_WIDTH'(5), m);
      push_lookup(base, 1'b1);                  // Hit again after restore
      for (int b = PB + SET_WIDTH; b < AW; b++) begin
         push_lookup(base ^ (32'd1 << b), 1'b1);   // Same set, other page
      end
      issue_lookups();
      end_test("misses", e0);
   endtask

   task automatic privilege_faults();
      int                    e0;
      immu_pkg::itlb_trans_t t;
      e0 = err_count;
      for (int k = 0; k < 4; k++) begin
         t = ref_trans[8 + k];
         t.sxe = k[0];
         t.uxe = k[1];
         write_trans(SET_WIDTH'(8 + k), t);
      end
      for (int k = 0; k < 4; k++) begin
         push_lookup({ref_match[8 + k].vpn, 13'(k * 4)}, 1'b0);
         push_lookup({ref_match[8 + k].vpn, 13'(k * 4)}, 1'b1);
      end
      issue_lookups();
      end_test("privilege", e0);
   endtask

   task automatic stream_lookups();
      int                   e0;
      logic [SET_WIDTH-1:0] s;
      logic [AW-1:0]        addr;
      e0 = err_count;
      for (int n = 0; n < 200; n++) begin
         s = SET_WIDTH'($urandom() % NUM_SETS);
         if ($urandom() % 4 == 0) begin
            addr = $urandom();                  // Mostly misses
         end else begin
            addr = {ref_match[s].vpn, 13'($urandom())};
         end
         push_lookup(addr, 1'($urandom()));
      end
      issue_lookups();
      end_test("streaming", e0);
   endtask

   task automatic probe_decode_edges();
      int            e0;
      logic [AW-1:0] rd;
      logic          acked;
      e0 = err_count;
      spr_read(16'h1000, rd);                   // Group 2, below the windows
      check_word("read of 1000", rd, '0);
      spr_read(immu_pkg::SPR_ITLBW0MR0 | 16'h0040, rd);   // Past the last set
      check_word("read of unpopulated match set", rd, '0);
      spr_read(immu_pkg::SPR_ITLBW1MR0, rd);
      check_word("read of way 1", rd, '0);
      spr_write(immu_pkg::SPR_ITLBW0MR0 | 16'h0040, 32'hffff_ffff);   // Must not alias set 0
      spr_write(immu_pkg::SPR_ITLBW1MR0, 32'hffff_ffff);
      spr_access(1'b1, 16'h1a00, 32'hffff_ffff, rd, acked);   // Group 3
      if (acked) begin
         note_failure("Group 3 write was acknowledged");
      end else begin
         $display("Group 3 access got no acknowledge within 10 cycles, as expected");
      end
      readback_set(SET_WIDTH'(0));
      push_lookup({ref_match[0].vpn, 13'h0010}, 1'b1);
      push_lookup({ref_match[1].vpn, 13'h1ffc}, 1'b0);
      push_lookup({ref_match[NUM_SETS-1].vpn, 13'h0000}, 1'b1);
      issue_lookups();
      end_test("decode_edges", e0);
   endtask

   initial begin
      void'($urandom(51));
      rst = 1'b1;
      fetch_req = 1'b0;
      fetch_addr = '0;
      fetch_super = 1'b0;
      spr_stb = 1'b0;
      spr_we = 1'b0;
      spr_addr = '0;
      spr_wdata = '0;
      repeat (4) @(negedge clk);                // Four rising edges in reset
      rst = 1'b0;
      if (spr_ack !== 1'b0 || rsp_valid !== 1'b0) begin
         note_failure("Ack or response valid not low after reset");
      end
      fill_and_read_back();
      translate_hits();
      detect_misses();
      privilege_faults();
      stream_lookups();
      probe_decode_edges();
      $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
immu_pkg.sv
tlb_dpram.sv
immu_spr_port.sv
immu.sv
fetch_xlate_stage.sv
immu_top.sv
tb_immu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_immu
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
